// ==== Bender.yml ====
package:
  name: boa_system

sources:
  - verilog/boa_pkg.sv
  - verilog/byte_fifo.sv
  - verilog/block_ram.sv
  - verilog/peri_uart.sv
  - verilog/peri_gpio.sv
  - verilog/mem_mux.sv
  - verilog/main.sv
  - target: test
    files:
      - testbench/main_chk.sv
      - testbench/main_tb.sv

// ==== build.f ====
verilog/boa_pkg.sv
verilog/byte_fifo.sv
verilog/block_ram.sv
verilog/peri_uart.sv
verilog/peri_gpio.sv
verilog/mem_mux.sv
verilog/main.sv
testbench/main_chk.sv
testbench/main_tb.sv

// ==== testbench/main_chk.sv ====
// Bus protocol checker, bound into the system top level for simulation.
module main_chk import boa_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              req_valid,
    input logic              req_ready,
    input logic              req_write,
    input logic [data_w-1:0] req_addr,
    input logic [data_w-1:0] req_wdata,
    input logic              resp_valid,
    input logic              txd
);
    int fail_count = 0;

    // Exactly one response per accepted request, one cycle later.
    resp_follows_accept: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && req_ready |=> resp_valid)
    else begin
        $error("resp_valid missing one cycle after an accepted request");
        fail_count++;
    end

    resp_needs_accept: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> $past(req_valid && req_ready))
    else begin
        $error("resp_valid without an accepted request");
        fail_count++;
    end

    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req_write)
                                    && $stable(req_addr) && $stable(req_wdata))
    else begin
        $error("request changed while stalled");
        fail_count++;
    end

    // Idle line once a reset edge has passed.
    txd_idle_in_reset: assert property (@(posedge clk) !rst_n |=> txd)
    else begin
        $error("txd low during reset");
        fail_count++;
    end
endmodule

bind main main_chk chk_i (.*);

// ==== testbench/main_tb.sv ====
// Directed testbench that acts as bus master to the system top level and loops the UART back.
module main_tb import boa_pkg::*; ();
    localparam int          ram_abits     = 6;
    localparam int          uart_buf      = 4;
    localparam int          clks_per_bit  = 8;
    localparam int          ram_words     = 2 ** ram_abits;
    localparam int          frame_clks    = 10 * clks_per_bit;
    localparam logic [31:0] unmapped_addr = 32'h1000_0000;
    localparam int          accept_limit  = 200;
    localparam int          resp_limit    = 10;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_write;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        txd;
    logic        rxd;
    logic [31:0] gpio_out;
    logic [31:0] gpio_oe;
    logic [31:0] gpio_in;
    logic [1:0]  irq;

    integer seed;
    int     errors;
    int     checks;
    int     stall_cycles;

    // UART loopback.
    assign rxd = txd;

    main #(
        .ram_abits   (ram_abits),
        .uart_buf    (uart_buf),
        .clks_per_bit(clks_per_bit)
    ) main_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .resp_valid(resp_valid),
        .resp_rdata(resp_rdata),
        .txd       (txd),
        .rxd       (rxd),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe),
        .gpio_in   (gpio_in),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Peripheral offset 'h400 lies beyond every register block.
    function automatic logic [31:0] target_addr(input target_e tgt, input logic [11:0] offs);
        case (tgt)
            tgt_ram:  return ram_base + 32'(offs);
            tgt_uart: return peri_base + 32'(uart_offs) + 32'(offs);
            tgt_gpio: return peri_base + 32'(gpio_offs) + 32'(offs);
            default:  return peri_base + 32'h400 + 32'(offs);
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic test_done(input string name, input int errors_before);
        $display("Test %-14s done, %0d errors", name, errors - errors_before);
    endtask

    // Returns at the rising edge that accepts the request.
    task automatic bus_request(input logic is_write, input logic [31:0] addr,
                               input logic [31:0] data);
        int n;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= is_write;
        req_addr  <= addr;
        req_wdata <= data;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < accept_limit) begin
            stall_cycles++;
            n++;
            @(negedge clk);
        end
        if (!req_ready) begin
            $display("Timeout at %0t: request to %h was never accepted", $time, addr);
            errors++;
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic bus_response(output logic [31:0] rdata);
        int n;
        n = 0;
        @(negedge clk);
        while (!resp_valid && n < resp_limit) begin
            n++;
            @(negedge clk);
        end
        if (!resp_valid) begin
            $display("Timeout at %0t: no response arrived for the request", $time);
            errors++;
        end
        rdata = resp_rdata;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_request(1'b1, addr, data);
        bus_response(ignored);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        bus_request(1'b0, addr, 32'h0);
        bus_response(rdata);
    endtask

    task automatic wait_rx_data();
        logic [31:0] status;
        int          n;
        n = 0;
        bus_read(target_addr(tgt_uart, reg_status), status);
        while (!status[3] && n < 100) begin
            n++;
            bus_read(target_addr(tgt_uart, reg_status), status);
        end
        if (!status[3]) begin
            $display("Timeout at %0t: UART receive FIFO stayed empty", $time);
            errors++;
        end
    endtask

    // Two quiet frame times mean every frame has been sent and received.
    task automatic wait_line_idle();
        int idle;
        int n;
        idle = 0;
        n = 0;
        while (idle < 2 * frame_clks && n < 2000) begin
            @(negedge clk);
            idle = txd ? idle + 1 : 0;
            n++;
        end
        if (idle < 2 * frame_clks) begin
            $display("Timeout at %0t: UART line never went idle", $time);
            errors++;
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_value(resp_valid, 1'b0, "resp_valid after reset");
        check_value(req_ready, 1'b1, "req_ready after reset");
        check_value(txd, 1'b1, "txd after reset");
        check_value(gpio_oe, 32'h0, "gpio_oe after reset");
        check_value(gpio_out, 32'h0, "gpio_out after reset");
        check_value(irq, 2'b01, "irq after reset");
        test_done("reset", e0);
    endtask

    task automatic test_ram_random();
        logic [31:0] shadow [ram_words];
        bit          used [ram_words];
        logic [31:0] got;
        int          idx;
        int          k;
        int          e0;
        e0 = errors;
        for (k = 0; k < 12; k++) begin
            idx = $random(seed) & (ram_words - 1);
            shadow[idx] = $random(seed);
            used[idx] = 1'b1;
            bus_write(target_addr(tgt_ram, 12'(idx * 4)), shadow[idx]);
        end
        for (k = 0; k < ram_words; k++) begin
            if (used[k]) begin
                bus_read(target_addr(tgt_ram, 12'(k * 4)), got);
                check_value(got, shadow[k], $sformatf("RAM word %0d", k));
            end
        end
        test_done("ram_random", e0);
    endtask

    // One read per cycle with each answer due one cycle after its request.
    task automatic test_ram_burst();
        logic [31:0] words [4];
        int          k;
        int          e0;
        e0 = errors;
        for (k = 0; k < 4; k++) begin
            words[k] = $random(seed);
            bus_write(target_addr(tgt_ram, 12'((40 + k) * 4)), words[k]);
        end
        for (k = 0; k <= 4; k++) begin
            @(posedge clk);
            if (k < 4) begin
                req_valid <= 1'b1;
                req_write <= 1'b0;
                req_addr  <= target_addr(tgt_ram, 12'((40 + k) * 4));
            end else begin
                req_valid <= 1'b0;
            end
            @(negedge clk);
            if (k < 4) begin
                check_value(req_ready, 1'b1, "req_ready during RAM burst");
            end
            if (k > 0) begin
                check_value(resp_valid, 1'b1, $sformatf("burst response %0d", k - 1));
                check_value(resp_rdata, words[k - 1], $sformatf("burst data %0d", k - 1));
            end
        end
        test_done("ram_burst", e0);
    endtask

    task automatic test_gpio();
        logic [31:0] out_val;
        logic [31:0] oe_val;
        logic [31:0] pins;
        logic [31:0] got;
        int          n;
        int          e0;
        e0 = errors;
        out_val = $random(seed);
        oe_val = $random(seed);
        pins = $random(seed);
        bus_write(target_addr(tgt_gpio, reg_out), out_val);
        check_value(gpio_out, out_val, "gpio_out pins");
        bus_write(target_addr(tgt_gpio, reg_oe), oe_val);
        check_value(gpio_oe, oe_val, "gpio_oe pins");
        bus_read(target_addr(tgt_gpio, reg_out), got);
        check_value(got, out_val, "GPIO output readback");
        bus_read(target_addr(tgt_gpio, reg_oe), got);
        check_value(got, oe_val, "GPIO enable readback");
        @(posedge clk);
        gpio_in <= pins;
        n = 0;
        bus_read(target_addr(tgt_gpio, reg_in), got);
        while (got !== pins && n < 10) begin
            n++;
            bus_read(target_addr(tgt_gpio, reg_in), got);
        end
        if (got !== pins) begin
            $display("Timeout at %0t: GPIO input register never showed the pins", $time);
            errors++;
        end
        check_value(got, pins, "GPIO input readback");
        test_done("gpio", e0);
    endtask

    task automatic test_uart_loopback();
        logic [7:0]  sent [4];
        logic [31:0] got;
        int          n;
        int          k;
        int          e0;
        e0 = errors;
        for (k = 0; k < 4; k++) begin
            sent[k] = 8'($random(seed));
            bus_write(target_addr(tgt_uart, reg_data), 32'(sent[k]));
        end
        check_value(irq[0], 1'b0, "irq[0] while bytes wait");
        for (k = 0; k < 4; k++) begin
            wait_rx_data();
            bus_read(target_addr(tgt_uart, reg_data), got);
            check_value(got, 32'(sent[k]), $sformatf("loopback byte %0d", k));
        end
        n = 0;
        while (!irq[0] && n < 400) begin
            n++;
            @(negedge clk);
        end
        if (!irq[0]) begin
            $display("Timeout at %0t: transmit FIFO never drained", $time);
            errors++;
        end
        check_value(irq[0], 1'b1, "irq[0] after transmission");
        test_done("uart_loopback", e0);
    endtask

    task automatic test_uart_full();
        logic [7:0]  sent [6];
        logic [31:0] got;
        int          k;
        int          e0;
        e0 = errors;
        stall_cycles = 0;
        for (k = 0; k < 6; k++) begin
            sent[k] = 8'($random(seed));
            bus_write(target_addr(tgt_uart, reg_data), 32'(sent[k]));
        end
        check_value(32'(stall_cycles > 0), 1, "req_ready low with transmit FIFO full");
        wait_line_idle();
        check_value(irq[1], 1'b1, "irq[1] with receive FIFO full");
        // Bytes 4 and 5 found the receive FIFO full.
        for (k = 0; k < 4; k++) begin
            bus_read(target_addr(tgt_uart, reg_data), got);
            check_value(got, 32'(sent[k]), $sformatf("held byte %0d", k));
        end
        bus_read(target_addr(tgt_uart, reg_data), got);
        check_value(got, 32'h0, "read of empty receive FIFO");
        check_value(irq, 2'b01, "irq after draining");
        test_done("uart_full", e0);
    endtask

    task automatic test_unmapped();
        logic [31:0] ram_word;
        logic [31:0] out_word;
        logic [31:0] got;
        int          e0;
        e0 = errors;
        ram_word = $random(seed);
        out_word = $random(seed);
        bus_write(target_addr(tgt_ram, 12'h000), ram_word);
        bus_write(target_addr(tgt_gpio, reg_out), out_word);
        bus_write(unmapped_addr, $random(seed));
        bus_write(target_addr(tgt_none, 12'h000), $random(seed));
        // First word past the RAM would alias word 0 if decoded.
        bus_write(target_addr(tgt_ram, 12'h100), $random(seed));
        bus_read(unmapped_addr, got);
        check_value(got, 32'h0, "unmapped read");
        bus_read(target_addr(tgt_none, 12'h000), got);
        check_value(got, 32'h0, "peripheral offset 'h400 read");
        bus_read(target_addr(tgt_ram, 12'h100), got);
        check_value(got, 32'h0, "read past RAM end");
        bus_read(target_addr(tgt_ram, 12'h000), got);
        check_value(got, ram_word, "RAM word 0 after unmapped writes");
        bus_read(target_addr(tgt_gpio, reg_out), got);
        check_value(got, out_word, "GPIO output after unmapped writes");
        check_value(gpio_out, out_word, "gpio_out pins after unmapped writes");
        test_done("unmapped", e0);
    endtask

    initial begin
        seed = 45;
        errors = 0;
        checks = 0;
        stall_cycles = 0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = 32'h0;
        req_wdata = 32'h0;
        gpio_in = 32'h0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_ram_random();
        test_ram_burst();
        test_gpio();
        test_uart_loopback();
        test_uart_full();
        test_unmapped();

        $display("Checks: %0d, errors: %0d, protocol failures: %0d",
                 checks, errors, main_i.chk_i.fail_count);
        if (errors == 0 && main_i.chk_i.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end
endmodule

// ==== verilog/block_ram.sv ====
// Single-port word RAM on the system bus, read data registered one cycle after select.
module block_ram import boa_pkg::*; #(
    // Word address bits.
    parameter int abits = 10
)(
    input  logic              clk,
    // Access strobe from the mux.
    input  logic              sel,
    input  logic              write,
    // Word address.
    input  logic [abits-1:0]  addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata
);
    logic [data_w-1:0] mem [2**abits];

    always_ff @(posedge clk) begin
        if (sel) begin
            if (write) begin
                mem[addr] <= wdata;
            end
            // Old contents on a write, ignored by the mux.
            rdata <= mem[addr];
        end
    end
endmodule

// ==== verilog/boa_pkg.sv ====
// Bus width, memory map and register offsets shared by the RTL and the testbench.
package boa_pkg;
    // Bus data and address width.
    localparam int data_w = 32;

    // Base address of the block RAM.
    localparam logic [data_w-1:0] ram_base  = 32'h4001_0000;
    // Base of the 4 KiB peripheral window.
    localparam logic [data_w-1:0] peri_base = 32'h8000_0000;

    // Register block offsets inside the peripheral window.
    localparam logic [11:0] uart_offs = 12'h000;
    localparam logic [11:0] gpio_offs = 12'h200;

    // UART registers.
    localparam logic [3:0] reg_data   = 4'h0;
    localparam logic [3:0] reg_status = 4'h4;

    // GPIO registers.
    localparam logic [3:0] reg_out = 4'h0;
    localparam logic [3:0] reg_oe  = 4'h4;
    localparam logic [3:0] reg_in  = 4'h8;

    // Routing targets of the address decoder.
    typedef enum logic [1:0] {
        tgt_ram,
        tgt_uart,
        tgt_gpio,
        tgt_none
    } target_e;
endpackage

// ==== verilog/byte_fifo.sv ====
// Synchronous byte FIFO with full and empty flags, used by the UART for both directions.
module byte_fifo #(
    // Number of entries.
    parameter int depth = 4
)(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       full,
    output logic       empty
);
    localparam int ptr_w = depth > 1 ? $clog2(depth) : 1;

    logic [7:0]       mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full     = count == (ptr_w + 1)'(depth);
    assign empty    = count == '0;
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    // Head entry is always visible.
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr == ptr_w'(depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr == ptr_w'(depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end
endmodule

// ==== verilog/main.sv ====
// System top level joining the bus master port to RAM, UART and GPIO, with UART interrupts.
module main import boa_pkg::*; #(
    // RAM word address bits.
    parameter int ram_abits    = 10,
    // UART FIFO depth.
    parameter int uart_buf     = 4,
    // UART bit period in clocks.
    parameter int clks_per_bit = 8
)(
    input  logic              clk,
    // Synchronous reset.
    input  logic              rst_n,

    // Bus master request.
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [data_w-1:0] req_addr,
    input  logic [data_w-1:0] req_wdata,
    output logic              req_ready,
    // Bus response.
    output logic              resp_valid,
    output logic [data_w-1:0] resp_rdata,

    output logic              txd,
    input  logic              rxd,

    output logic [data_w-1:0] gpio_out,
    output logic [data_w-1:0] gpio_oe,
    input  logic [data_w-1:0] gpio_in,

    // Bit 0 transmit empty, bit 1 receive full.
    output logic [1:0]        irq
);
    logic              ram_sel;
    logic              uart_sel;
    logic              gpio_sel;
    logic              tgt_write;
    logic [11:0]       tgt_addr;
    logic [data_w-1:0] tgt_wdata;
    logic [data_w-1:0] ram_rdata;
    logic [data_w-1:0] uart_rdata;
    logic [data_w-1:0] gpio_rdata;
    logic              uart_busy;

    mem_mux #(.ram_abits(ram_abits)) mux (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .resp_valid(resp_valid),
        .resp_rdata(resp_rdata),
        .uart_busy (uart_busy),
        .ram_rdata (ram_rdata),
        .uart_rdata(uart_rdata),
        .gpio_rdata(gpio_rdata),
        .ram_sel   (ram_sel),
        .uart_sel  (uart_sel),
        .gpio_sel  (gpio_sel),
        .tgt_write (tgt_write),
        .tgt_addr  (tgt_addr),
        .tgt_wdata (tgt_wdata)
    );

    block_ram #(.abits(ram_abits)) ram (
        .clk  (clk),
        .sel  (ram_sel),
        .write(tgt_write),
        .addr (tgt_addr[ram_abits-1:0]),
        .wdata(tgt_wdata),
        .rdata(ram_rdata)
    );

    // UART flags drive the interrupt lines directly.
    peri_uart #(.depth(uart_buf), .clks_per_bit(clks_per_bit)) uart (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (uart_sel),
        .write   (tgt_write),
        .addr    (tgt_addr[3:0]),
        .wdata   (tgt_wdata),
        .rdata   (uart_rdata),
        .busy    (uart_busy),
        .txd     (txd),
        .rxd     (rxd),
        .tx_empty(irq[0]),
        .rx_full (irq[1])
    );

    peri_gpio gpio (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (gpio_sel),
        .write   (tgt_write),
        .addr    (tgt_addr[3:0]),
        .wdata   (tgt_wdata),
        .rdata   (gpio_rdata),
        .gpio_in (gpio_in),
        .gpio_out(gpio_out),
        .gpio_oe (gpio_oe)
    );
endmodule

// ==== verilog/mem_mux.sv ====
// Address decoder routing bus requests to RAM, UART or GPIO and returning their responses.
module mem_mux import boa_pkg::*; #(
    // RAM word address bits, sets the RAM region size.
    parameter int ram_abits = 10
)(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [data_w-1:0] req_addr,
    input  logic [data_w-1:0] req_wdata,
    output logic              req_ready,
    output logic              resp_valid,
    output logic [data_w-1:0] resp_rdata,
    input  logic              uart_busy,
    input  logic [data_w-1:0] ram_rdata,
    input  logic [data_w-1:0] uart_rdata,
    input  logic [data_w-1:0] gpio_rdata,
    output logic              ram_sel,
    output logic              uart_sel,
    output logic              gpio_sel,
    output logic              tgt_write,
    // RAM word index or peripheral register offset.
    output logic [11:0]       tgt_addr,
    output logic [data_w-1:0] tgt_wdata
);
    localparam int ram_lsb = ram_abits + 2;

    target_e target;
    target_e target_q;
    logic    hold;
    logic    accept;

    // Peripheral blocks are 16 bytes each.
    always_comb begin
        target = tgt_none;
        if (req_addr[data_w-1:ram_lsb] == ram_base[data_w-1:ram_lsb]) begin
            target = tgt_ram;
        end else if (req_addr[data_w-1:12] == peri_base[data_w-1:12]) begin
            if (req_addr[11:4] == uart_offs[11:4]) begin
                target = tgt_uart;
            end else if (req_addr[11:4] == gpio_offs[11:4]) begin
                target = tgt_gpio;
            end
        end
    end

    // Stall a UART data write while its transmit FIFO is full.
    assign hold = req_valid && req_write && target == tgt_uart
                  && req_addr[3:0] == reg_data && uart_busy;
    assign req_ready = !hold;
    assign accept    = req_valid && req_ready;

    assign ram_sel   = accept && target == tgt_ram;
    assign uart_sel  = accept && target == tgt_uart;
    assign gpio_sel  = accept && target == tgt_gpio;
    assign tgt_write = req_write;
    assign tgt_addr  = target == tgt_ram ? req_addr[13:2] : req_addr[11:0];
    assign tgt_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            target_q   <= tgt_none;
        end else begin
            resp_valid <= accept;
            // Writes and unmapped reads answer zero.
            if (accept && !req_write) begin
                target_q <= target;
            end else begin
                target_q <= tgt_none;
            end
        end
    end

    always_comb begin
        case (target_q)
            tgt_ram:  resp_rdata = ram_rdata;
            tgt_uart: resp_rdata = uart_rdata;
            tgt_gpio: resp_rdata = gpio_rdata;
            default:  resp_rdata = '0;
        endcase
    end
endmodule

// ==== verilog/peri_gpio.sv ====
// GPIO peripheral with output, output-enable and synchronized input registers.
module peri_gpio import boa_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sel,
    input  logic              write,
    input  logic [3:0]        addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    input  logic [data_w-1:0] gpio_in,
    output logic [data_w-1:0] gpio_out,
    output logic [data_w-1:0] gpio_oe
);
    logic [data_w-1:0] in_meta;
    logic [data_w-1:0] in_sync;

    // Two-flop synchronizer on the pins.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            gpio_oe  <= '0;
        end else if (sel && write) begin
            // Input register is read only.
            case (addr)
                reg_out: gpio_out <= wdata;
                reg_oe:  gpio_oe  <= wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sel && !write) begin
            case (addr)
                reg_out: rdata <= gpio_out;
                reg_oe:  rdata <= gpio_oe;
                reg_in:  rdata <= in_sync;
                default: rdata <= '0;
            endcase
        end
    end
endmodule

// ==== verilog/peri_uart.sv ====
// UART peripheral with data and status registers, FIFO-buffered in both directions.
module peri_uart import boa_pkg::*; #(
    // FIFO depth for each direction.
    parameter int depth        = 4,
    // Bit period in clocks.
    parameter int clks_per_bit = 8
)(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sel,
    input  logic              write,
    input  logic [3:0]        addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    // Transmit FIFO cannot take a write.
    output logic              busy,
    output logic              txd,
    input  logic              rxd,
    output logic              tx_empty,
    output logic              rx_full
);
    localparam int div_w = $clog2(clks_per_bit);
    localparam logic [div_w-1:0] bit_last  = div_w'(clks_per_bit - 1);
    localparam logic [div_w-1:0] half_last = div_w'(clks_per_bit / 2 - 1);

    logic             tx_push;
    logic             tx_pop;
    logic [7:0]       tx_data;
    logic             tx_full;
    logic             tx_active;
    logic [div_w-1:0] tx_div;
    logic [3:0]       tx_cnt;
    logic [8:0]       tx_shift;

    logic             rx_pop;
    logic             rx_push;
    logic [7:0]       rx_data;
    logic             rx_empty;
    logic             rx_meta;
    logic             rx_s;
    logic             rx_active;
    logic [div_w-1:0] rx_div;
    logic [3:0]       rx_cnt;
    logic [7:0]       rx_shift;

    assign tx_push = sel && write && addr == reg_data;
    assign rx_pop  = sel && !write && addr == reg_data;
    assign busy    = tx_full;
    // Load a new frame whenever the transmitter is idle.
    assign tx_pop  = !tx_active && !tx_empty;

    byte_fifo #(.depth(depth)) tx_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (tx_push),
        .push_data(wdata[7:0]),
        .pop      (tx_pop),
        .pop_data (tx_data),
        .full     (tx_full),
        .empty    (tx_empty)
    );

    byte_fifo #(.depth(depth)) rx_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (rx_push),
        .push_data(rx_shift),
        .pop      (rx_pop),
        .pop_data (rx_data),
        .full     (rx_full),
        .empty    (rx_empty)
    );

    always_ff @(posedge clk) begin
        if (sel && !write) begin
            case (addr)
                reg_data:   rdata <= rx_empty ? '0 : data_w'(rx_data);
                reg_status: rdata <= data_w'({!rx_empty, rx_full, tx_full, tx_empty});
                default:    rdata <= '0;
            endcase
        end
    end

    // Transmitter: start bit, 8 data bits LSB first, stop bit.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_active <= 1'b0;
            tx_div    <= '0;
            tx_cnt    <= '0;
            txd       <= 1'b1;
        end else if (!tx_active) begin
            if (!tx_empty) begin
                tx_active <= 1'b1;
                tx_div    <= '0;
                tx_cnt    <= '0;
                txd       <= 1'b0;
            end
        end else if (tx_div == bit_last) begin
            tx_div <= '0;
            if (tx_cnt == 4'd9) begin
                tx_active <= 1'b0;
            end else begin
                txd    <= tx_shift[0];
                tx_cnt <= tx_cnt + 1'b1;
            end
        end else begin
            tx_div <= tx_div + 1'b1;
        end
    end

    // Data bits with the stop bit behind them.
    always_ff @(posedge clk) begin
        if (tx_pop) begin
            tx_shift <= {1'b1, tx_data};
        end else if (tx_active && tx_div == bit_last) begin
            tx_shift <= {1'b1, tx_shift[8:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_s    <= rx_meta;
        end
    end

    // Receiver samples at mid-bit, counted from the start edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_active <= 1'b0;
            rx_div    <= '0;
            rx_cnt    <= '0;
            rx_push   <= 1'b0;
        end else begin
            rx_push <= 1'b0;
            if (!rx_active) begin
                if (!rx_s) begin
                    rx_active <= 1'b1;
                    rx_div    <= half_last;
                    rx_cnt    <= '0;
                end
            end else if (rx_div != '0) begin
                rx_div <= rx_div - 1'b1;
            end else begin
                rx_div <= bit_last;
                rx_cnt <= rx_cnt + 1'b1;
                if (rx_cnt == 4'd0 && rx_s) begin
                    // Glitch, not a start bit.
                    rx_active <= 1'b0;
                end else if (rx_cnt == 4'd9) begin
                    rx_active <= 1'b0;
                    rx_push   <= rx_s;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_active && rx_div == '0 && rx_cnt != 4'd0 && rx_cnt != 4'd9) begin
            rx_shift <= {rx_s, rx_shift[7:1]};
        end
    end
endmodule
